//--- verilog/cpu_pkg.sv
package cpu_pkg;

  // datapath sizes
  localparam int DATA_W      = 32;
  localparam int ADDR_W      = 16;
  localparam int NUM_THREADS = 4;
  localparam int SLOT_W      = 2;

  // command and message field widths
  localparam int CMD_W = 4;
  localparam int MSG_W = 8;

  // command sequencer states
  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ALU_BEGIN    = 2'd1,
    FINISH_BEGIN = 2'd2
  } state_t;

  // command codes, bits 31:28 of the command word
  localparam logic [CMD_W-1:0] CMD_FORK = 4'h1;
  localparam logic [CMD_W-1:0] CMD_STOP = 4'h2;

  // inter-cpu message codes, zero means no message
  localparam logic [MSG_W-1:0] CPU_R_NONE      = 8'h00;
  localparam logic [MSG_W-1:0] CPU_R_FORK_THRD = 8'h01;
  localparam logic [MSG_W-1:0] CPU_R_FORK_DONE = 8'h02;
  localparam logic [MSG_W-1:0] CPU_R_STOP_THRD = 8'h03;
  localparam logic [MSG_W-1:0] CPU_R_STOP_DONE = 8'h04;

endpackage

//--- verilog/cpu_msg_if.sv
`timescale 1ns/1ps

interface cpu_msg_if;

  // request side, driven by the thread controller
  logic [cpu_pkg::MSG_W-1:0]  req_msg;
  logic [cpu_pkg::ADDR_W-1:0] req_addr;
  logic [cpu_pkg::DATA_W-1:0] req_data;
  logic [cpu_pkg::SLOT_W-1:0] req_slot;

  // response side, driven by the dispatcher
  logic [cpu_pkg::MSG_W-1:0]  rsp_msg;
  logic [cpu_pkg::SLOT_W-1:0] rsp_slot;

  modport ctlr (
    output req_msg,
    output req_addr,
    output req_data,
    output req_slot,
    input  rsp_msg,
    input  rsp_slot
  );

  modport disp (
    input  req_msg,
    input  req_addr,
    input  req_data,
    input  req_slot,
    output rsp_msg,
    output rsp_slot
  );

endinterface

//--- verilog/stage_seq.sv
`timescale 1ns/1ps

module stage_seq (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cmd_valid,
  input  logic [cpu_pkg::DATA_W-1:0] command,
  input  logic [cpu_pkg::DATA_W-1:0] src0_in,
  input  logic [cpu_pkg::DATA_W-1:0] src1_in,
  input  logic                       next_state,
  output cpu_pkg::state_t            state,
  output logic [cpu_pkg::DATA_W-1:0] command_q,
  output logic [cpu_pkg::DATA_W-1:0] src0,
  output logic [cpu_pkg::DATA_W-1:0] src1,
  output logic                       busy,
  output logic                       cmd_done
);

  logic accept;

  // new commands only land while the sequencer is free
  assign accept = cmd_valid && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= cpu_pkg::ST_IDLE;
      busy     <= 1'b0;
      cmd_done <= 1'b0;
    end else begin
      cmd_done <= 1'b0;
      case (state)
        cpu_pkg::ST_IDLE: begin
          if (accept) begin
            state <= cpu_pkg::ALU_BEGIN;
            busy  <= 1'b1;
          end
        end
        cpu_pkg::ALU_BEGIN: begin
          // controller decides how long the alu stage lasts
          if (next_state) begin
            state <= cpu_pkg::FINISH_BEGIN;
          end
        end
        cpu_pkg::FINISH_BEGIN: begin
          state    <= cpu_pkg::ST_IDLE;
          busy     <= 1'b0;
          cmd_done <= 1'b1;
        end
        default: begin
          state <= cpu_pkg::ST_IDLE;
          busy  <= 1'b0;
        end
      endcase
    end
  end

  // command word and operands held for the whole sequence
  always_ff @(posedge clk) begin
    if (accept) begin
      command_q <= command;
      src0      <= src0_in;
      src1      <= src1_in;
    end
  end

endmodule

//--- verilog/thread_ctlr.sv
`timescale 1ns/1ps

module thread_ctlr (
  input  logic                       clk,
  input  logic                       rst,
  input  cpu_pkg::state_t            state,
  input  logic [cpu_pkg::DATA_W-1:0] command,
  input  logic [cpu_pkg::DATA_W-1:0] src0,
  input  logic [cpu_pkg::DATA_W-1:0] src1,
  input  logic [cpu_pkg::ADDR_W-1:0] base_addr,
  input  logic [cpu_pkg::DATA_W-1:0] base_addr_data,
  input  logic                       disp_online,
  cpu_msg_if.ctlr                    msg,
  output logic                       next_state
);

  logic [cpu_pkg::CMD_W-1:0]  cmd_code;
  logic                       is_fork;
  logic                       is_stop;
  logic                       in_alu;
  logic                       signal_sent;
  logic [cpu_pkg::SLOT_W-1:0] stop_slot;
  logic                       fork_done;
  logic                       stop_done;

  assign cmd_code  = command[cpu_pkg::DATA_W-1 -: cpu_pkg::CMD_W];
  assign is_fork   = (cmd_code == cpu_pkg::CMD_FORK);
  assign is_stop   = (cmd_code == cpu_pkg::CMD_STOP);
  assign in_alu    = (state == cpu_pkg::ALU_BEGIN);
  assign stop_slot = src0[cpu_pkg::SLOT_W-1:0];

  // completions only count once our own request went out
  assign fork_done = is_fork && signal_sent && (msg.rsp_msg == cpu_pkg::CPU_R_FORK_DONE);
  assign stop_done = is_stop && signal_sent && (msg.rsp_msg == cpu_pkg::CPU_R_STOP_DONE) &&
                     (msg.rsp_slot == stop_slot);

  // anything other than fork or stop finishes straight away
  assign next_state = in_alu && ((!is_fork && !is_stop) || fork_done || stop_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      msg.req_msg <= cpu_pkg::CPU_R_NONE;
      signal_sent <= 1'b0;
    end else begin
      msg.req_msg <= cpu_pkg::CPU_R_NONE;
      if (next_state) begin
        signal_sent <= 1'b0;
      end else if (in_alu && !signal_sent) begin
        if (is_fork && disp_online) begin
          msg.req_msg <= cpu_pkg::CPU_R_FORK_THRD;
          signal_sent <= 1'b1;
        end else if (is_stop) begin
          msg.req_msg <= cpu_pkg::CPU_R_STOP_THRD;
          signal_sent <= 1'b1;
        end
      end
    end
  end

  // request payload, only meaningful alongside req_msg
  always_ff @(posedge clk) begin
    if (in_alu && !signal_sent) begin
      msg.req_addr <= src0[cpu_pkg::ADDR_W-1:0] + base_addr;
      // a zero data operand means the thread gets no data pointer
      msg.req_data <= (src1 == '0) ? '0 : src1 + base_addr_data;
      msg.req_slot <= stop_slot;
    end
  end

endmodule

//--- verilog/thread_dispatcher.sv
`timescale 1ns/1ps

module thread_dispatcher (
  input  logic                       clk,
  input  logic                       rst,
  cpu_msg_if.disp                    msg,
  input  logic [cpu_pkg::SLOT_W-1:0] free_slot,
  input  logic                       exit_valid,
  input  logic [cpu_pkg::SLOT_W-1:0] exit_slot,
  output logic                       wr_en,
  output logic                       clr_en,
  output logic                       exit_en,
  output logic [cpu_pkg::SLOT_W-1:0] wr_slot,
  output logic [cpu_pkg::SLOT_W-1:0] clr_slot,
  output logic [cpu_pkg::SLOT_W-1:0] exit_clr_slot,
  output logic [cpu_pkg::ADDR_W-1:0] wr_addr,
  output logic [cpu_pkg::DATA_W-1:0] wr_data,
  output logic                       spawn_valid,
  output logic [cpu_pkg::SLOT_W-1:0] spawn_slot,
  output logic [cpu_pkg::ADDR_W-1:0] spawn_addr,
  output logic [cpu_pkg::DATA_W-1:0] spawn_data
);

  logic fork_req;
  logic stop_req;

  assign fork_req = (msg.req_msg == cpu_pkg::CPU_R_FORK_THRD);
  assign stop_req = (msg.req_msg == cpu_pkg::CPU_R_STOP_THRD);

  // exits bypass the message path and hit the table at the next edge
  assign exit_en       = exit_valid;
  assign exit_clr_slot = exit_slot;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en       <= 1'b0;
      clr_en      <= 1'b0;
      msg.rsp_msg <= cpu_pkg::CPU_R_NONE;
    end else begin
      wr_en  <= fork_req;
      clr_en <= stop_req;
      if (fork_req) begin
        msg.rsp_msg <= cpu_pkg::CPU_R_FORK_DONE;
      end else if (stop_req) begin
        // a stop on a free slot is harmless, still acknowledged
        msg.rsp_msg <= cpu_pkg::CPU_R_STOP_DONE;
      end else begin
        msg.rsp_msg <= cpu_pkg::CPU_R_NONE;
      end
    end
  end

  always_ff @(posedge clk) begin
    wr_slot      <= free_slot;
    wr_addr      <= msg.req_addr;
    wr_data      <= msg.req_data;
    clr_slot     <= msg.req_slot;
    msg.rsp_slot <= fork_req ? free_slot : msg.req_slot;
  end

  // spawn report mirrors the table write of the fork
  assign spawn_valid = wr_en;
  assign spawn_slot  = wr_slot;
  assign spawn_addr  = wr_addr;
  assign spawn_data  = wr_data;

endmodule

//--- verilog/thread_table.sv
`timescale 1ns/1ps

module thread_table (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            wr_en,
  input  logic                            clr_en,
  input  logic                            exit_en,
  input  logic [cpu_pkg::SLOT_W-1:0]      wr_slot,
  input  logic [cpu_pkg::SLOT_W-1:0]      clr_slot,
  input  logic [cpu_pkg::SLOT_W-1:0]      exit_clr_slot,
  input  logic [cpu_pkg::ADDR_W-1:0]      wr_addr,
  input  logic [cpu_pkg::DATA_W-1:0]      wr_data,
  output logic [cpu_pkg::SLOT_W-1:0]      free_slot,
  output logic                            disp_online,
  output logic [cpu_pkg::NUM_THREADS-1:0] thread_mask
);

  logic [cpu_pkg::NUM_THREADS-1:0] valid;

  // clears first, so a write in the same cycle still wins
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else begin
      if (exit_en) begin
        valid[exit_clr_slot] <= 1'b0;
      end
      if (clr_en) begin
        valid[clr_slot] <= 1'b0;
      end
      if (wr_en) begin
        valid[wr_slot] <= 1'b1;
      end
    end
  end

  // top-down scan so the lowest free slot wins
  always_comb begin
    free_slot = '0;
    for (int i = cpu_pkg::NUM_THREADS - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_slot = cpu_pkg::SLOT_W'(i);
      end
    end
  end

  assign disp_online = ~&valid;
  assign thread_mask = valid;

endmodule

//--- verilog/thread_unit.sv
`timescale 1ns/1ps

module thread_unit (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            cmd_valid,
  input  logic [cpu_pkg::DATA_W-1:0]      command,
  input  logic [cpu_pkg::DATA_W-1:0]      src0,
  input  logic [cpu_pkg::DATA_W-1:0]      src1,
  input  logic [cpu_pkg::ADDR_W-1:0]      base_addr,
  input  logic [cpu_pkg::DATA_W-1:0]      base_addr_data,
  input  logic                            exit_valid,
  input  logic [cpu_pkg::SLOT_W-1:0]      exit_slot,
  output logic                            busy,
  output logic                            cmd_done,
  output logic                            spawn_valid,
  output logic [cpu_pkg::SLOT_W-1:0]      spawn_slot,
  output logic [cpu_pkg::ADDR_W-1:0]      spawn_addr,
  output logic [cpu_pkg::DATA_W-1:0]      spawn_data,
  output logic [cpu_pkg::NUM_THREADS-1:0] thread_mask
);

  cpu_pkg::state_t            state;
  logic [cpu_pkg::DATA_W-1:0] command_q;
  logic [cpu_pkg::DATA_W-1:0] src0_q;
  logic [cpu_pkg::DATA_W-1:0] src1_q;
  logic                       next_state;
  logic                       disp_online;
  logic [cpu_pkg::SLOT_W-1:0] free_slot;
  logic                       wr_en;
  logic                       clr_en;
  logic                       exit_en;
  logic [cpu_pkg::SLOT_W-1:0] wr_slot;
  logic [cpu_pkg::SLOT_W-1:0] clr_slot;
  logic [cpu_pkg::SLOT_W-1:0] exit_clr_slot;
  logic [cpu_pkg::ADDR_W-1:0] wr_addr;
  logic [cpu_pkg::DATA_W-1:0] wr_data;

  cpu_msg_if msg ();

  stage_seq u_seq (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .command    (command),
    .src0_in    (src0),
    .src1_in    (src1),
    .next_state (next_state),
    .state      (state),
    .command_q  (command_q),
    .src0       (src0_q),
    .src1       (src1_q),
    .busy       (busy),
    .cmd_done   (cmd_done)
  );

  thread_ctlr u_ctlr (
    .clk            (clk),
    .rst            (rst),
    .state          (state),
    .command        (command_q),
    .src0           (src0_q),
    .src1           (src1_q),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .disp_online    (disp_online),
    .msg            (msg.ctlr),
    .next_state     (next_state)
  );

  thread_dispatcher u_disp (
    .clk           (clk),
    .rst           (rst),
    .msg           (msg.disp),
    .free_slot     (free_slot),
    .exit_valid    (exit_valid),
    .exit_slot     (exit_slot),
    .wr_en         (wr_en),
    .clr_en        (clr_en),
    .exit_en       (exit_en),
    .wr_slot       (wr_slot),
    .clr_slot      (clr_slot),
    .exit_clr_slot (exit_clr_slot),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .spawn_valid   (spawn_valid),
    .spawn_slot    (spawn_slot),
    .spawn_addr    (spawn_addr),
    .spawn_data    (spawn_data)
  );

  thread_table u_table (
    .clk           (clk),
    .rst           (rst),
    .wr_en         (wr_en),
    .clr_en        (clr_en),
    .exit_en       (exit_en),
    .wr_slot       (wr_slot),
    .clr_slot      (clr_slot),
    .exit_clr_slot (exit_clr_slot),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .free_slot     (free_slot),
    .disp_online   (disp_online),
    .thread_mask   (thread_mask)
  );

endmodule

//--- test/thread_unit_tb.sv
`timescale 1ns/1ps

module thread_unit_tb;

  typedef struct packed {
    logic [cpu_pkg::SLOT_W-1:0] slot;
    logic [cpu_pkg::ADDR_W-1:0] addr;
    logic [cpu_pkg::DATA_W-1:0] data;
  } spawn_t;

  logic                            clk;
  logic                            rst;
  logic                            cmd_valid;
  logic [cpu_pkg::DATA_W-1:0]      command;
  logic [cpu_pkg::DATA_W-1:0]      src0;
  logic [cpu_pkg::DATA_W-1:0]      src1;
  logic [cpu_pkg::ADDR_W-1:0]      base_addr;
  logic [cpu_pkg::DATA_W-1:0]      base_addr_data;
  logic                            exit_valid;
  logic [cpu_pkg::SLOT_W-1:0]      exit_slot;
  logic                            busy;
  logic                            cmd_done;
  logic                            spawn_valid;
  logic [cpu_pkg::SLOT_W-1:0]      spawn_slot;
  logic [cpu_pkg::ADDR_W-1:0]      spawn_addr;
  logic [cpu_pkg::DATA_W-1:0]      spawn_data;
  logic [cpu_pkg::NUM_THREADS-1:0] thread_mask;

  // expectations come from the stimulus side, the checker only reads them
  spawn_t                          exp_spawn = '0;
  logic [cpu_pkg::NUM_THREADS-1:0] model_mask = '0;
  int                              spawns_expected = 0;
  int                              spawns_seen = 0;
  logic [15:0]                     lfsr;

  thread_unit DUT (
    .clk            (clk),
    .rst            (rst),
    .cmd_valid      (cmd_valid),
    .command        (command),
    .src0           (src0),
    .src1           (src1),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .exit_valid     (exit_valid),
    .exit_slot      (exit_slot),
    .busy           (busy),
    .cmd_done       (cmd_done),
    .spawn_valid    (spawn_valid),
    .spawn_slot     (spawn_slot),
    .spawn_addr     (spawn_addr),
    .spawn_data     (spawn_data),
    .thread_mask    (thread_mask)
  );

  always #4 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // expected spawn of a fork against a given occupancy
  function automatic spawn_t spawn_model(input logic [cpu_pkg::DATA_W-1:0] s0,
                                         input logic [cpu_pkg::DATA_W-1:0] s1,
                                         input logic [cpu_pkg::ADDR_W-1:0] ba,
                                         input logic [cpu_pkg::DATA_W-1:0] bd,
                                         input logic [cpu_pkg::NUM_THREADS-1:0] mask);
    spawn_t r;
    int     idx;
    idx = 0;
    while (idx < cpu_pkg::NUM_THREADS - 1 && mask[idx]) begin
      idx++;
    end
    r.slot = idx[cpu_pkg::SLOT_W-1:0];
    r.addr = s0[cpu_pkg::ADDR_W-1:0] + ba;
    r.data = (s1 == '0) ? '0 : s1 + bd;
    return r;
  endfunction

  task automatic stop_failed();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    $display("[FAIL] time %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
    stop_failed();
  endtask

  task automatic plain_error(input string what);
    $display("ERROR at %0d ns: %s", $time, what);
    stop_failed();
  endtask

  // compare every spawn, and the mask whenever a command ends
  always @(negedge clk) begin
    if (!rst && spawn_valid) begin
      assert (spawns_seen < spawns_expected)
        else plain_error("spawn_valid pulsed with no fork outstanding");
      assert (spawn_slot == exp_spawn.slot)
        else value_error("spawn_slot", 32'(spawn_slot), 32'(exp_spawn.slot));
      assert (spawn_addr == exp_spawn.addr)
        else value_error("spawn_addr", 32'(spawn_addr), 32'(exp_spawn.addr));
      assert (spawn_data == exp_spawn.data)
        else value_error("spawn_data", spawn_data, exp_spawn.data);
      spawns_seen <= spawns_seen + 1;
    end
    if (!rst && cmd_done) begin
      assert (thread_mask == model_mask)
        else value_error("thread_mask", 32'(thread_mask), 32'(model_mask));
    end
  end

  // one lfsr step per bit, msb drawn first
  task automatic draw_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic drive_cmd(input logic [3:0] code, input logic [31:0] s0,
                           input logic [31:0] s1);
    logic [31:0] low;
    draw_bits(28, low);
    cmd_valid = 1'b1;
    command   = {code, low[27:0]};
    src0      = s0;
    src1      = s1;
  endtask

  task automatic expect_spawn(input logic [31:0] s0, input logic [31:0] s1,
                              input logic [cpu_pkg::NUM_THREADS-1:0] mask_before);
    spawn_t s;
    s = spawn_model(s0, s1, base_addr, base_addr_data, mask_before);
    exp_spawn       <= s;
    model_mask      <= mask_before | (4'b1 << s.slot);
    spawns_expected <= spawns_expected + 1;
  endtask

  task automatic wait_done(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    cmd_valid = 1'b0;
    while (!cmd_done) begin
      assert (cycles < 100) else plain_error({"no cmd_done after ", what});
      @(negedge clk);
      cycles++;
    end
    assert (!busy) else value_error("busy", 32'(busy), 32'd0);
    assert (spawns_seen == spawns_expected)
      else plain_error({"wrong number of spawns after ", what});
  endtask

  task automatic do_fork(input logic [31:0] s0, input logic [31:0] s1);
    logic [31:0] word;
    @(negedge clk);
    draw_bits(16, word);
    base_addr = word[15:0];
    draw_bits(32, word);
    base_addr_data = word;
    expect_spawn(s0, s1, model_mask);
    drive_cmd(cpu_pkg::CMD_FORK, s0, s1);
    wait_done("fork");
  endtask

  task automatic do_stop(input logic [1:0] slot);
    logic [31:0] word;
    @(negedge clk);
    draw_bits(30, word);
    model_mask <= model_mask & ~(4'b1 << slot);
    drive_cmd(cpu_pkg::CMD_STOP, {word[29:0], slot}, 32'd0);
    wait_done("stop");
  endtask

  // the fork sent one cycle into the no-op must be dropped
  task automatic noop_with_ignored_fork();
    logic [31:0] word;
    logic [31:0] s1;
    logic [3:0]  code;
    draw_bits(4, word);
    code = word[3:0];
    if (code == cpu_pkg::CMD_FORK || code == cpu_pkg::CMD_STOP) begin
      code = 4'h0;
    end
    @(negedge clk);
    drive_cmd(code, 32'd0, 32'd0);
    @(negedge clk);
    assert (busy) else plain_error("busy low one cycle after a command was accepted");
    draw_bits(32, word);
    draw_bits(32, s1);
    drive_cmd(cpu_pkg::CMD_FORK, word, s1);
    wait_done("no-op");
  endtask

  task automatic fork_when_full(input logic [1:0] exit_k);
    logic [31:0] s0;
    logic [31:0] s1;
    draw_bits(32, s0);
    draw_bits(32, s1);
    @(negedge clk);
    drive_cmd(cpu_pkg::CMD_FORK, s0, s1);
    @(negedge clk);
    cmd_valid = 1'b0;
    repeat (20) begin
      @(negedge clk);
      assert (busy) else plain_error("busy dropped while the table was full");
    end
    // a thread leaves on its own and frees one slot
    exit_valid = 1'b1;
    exit_slot  = exit_k;
    expect_spawn(s0, s1, model_mask & ~(4'b1 << exit_k));
    @(negedge clk);
    exit_valid = 1'b0;
    wait_done("fork on a full table");
  endtask

  initial begin
    logic [31:0] s0;
    logic [31:0] s1;
    logic [31:0] pick;
    clk            = 1'b0;
    rst            = 1'b1;
    cmd_valid      = 1'b0;
    command        = '0;
    src0           = '0;
    src1           = '0;
    base_addr      = '0;
    base_addr_data = '0;
    exit_valid     = 1'b0;
    exit_slot      = '0;
    lfsr           = 16'd46718;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (!busy && !cmd_done && !spawn_valid)
      else plain_error("busy, cmd_done or spawn_valid high after reset");
    assert (thread_mask == '0) else value_error("thread_mask", 32'(thread_mask), 32'd0);

    // fill every slot, one fork without a data operand
    for (int n = 0; n < cpu_pkg::NUM_THREADS; n++) begin
      draw_bits(32, s0);
      draw_bits(32, s1);
      if (n == 2) begin
        s1 = '0;
      end
      do_fork(s0, s1);
    end
    draw_bits(2, pick);
    fork_when_full(pick[1:0]);
    do_stop(2'd1);
    do_stop(2'd1);
    draw_bits(32, s0);
    draw_bits(32, s1);
    do_fork(s0, s1);
    noop_with_ignored_fork();

    // random mix of forks, stops and no-ops
    for (int n = 0; n < 16; n++) begin
      draw_bits(2, pick);
      if (pick[1:0] == 2'd3) begin
        noop_with_ignored_fork();
      end else if (pick[1:0] == 2'd2 || model_mask == '1) begin
        draw_bits(2, pick);
        do_stop(pick[1:0]);
      end else begin
        draw_bits(32, s0);
        draw_bits(32, s1);
        do_fork(s0, s1);
      end
    end
    @(negedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- thread_unit.f
verilog/cpu_pkg.sv
verilog/cpu_msg_if.sv
verilog/stage_seq.sv
verilog/thread_ctlr.sv
verilog/thread_dispatcher.sv
verilog/thread_table.sv
verilog/thread_unit.sv
test/thread_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module thread_unit_tb \
  -f thread_unit.f -o thread_unit_sim &&
./obj_dir/thread_unit_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run_sim: testbench passed" ||
{ echo "run_sim: testbench failed"; exit 1; }
